//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= tb_sens_top
FILELIST  ?= list.f
OBJDIR    ?= obj_dir

.PHONY: sim clean

# build and run, a $$fatal in the testbench gives a nonzero exit
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

//--- list.f
+incdir+logic
logic/sens_pkg.sv
logic/sens_trigger.sv
logic/sens_frame_fsm.sv
logic/sens_pixel_gen.sv
logic/sens_top.sv
sim/tb_sens_top.sv

//--- logic/sens_frame_fsm.sv
`timescale 1ns/1ps
`default_nettype none
`include "sens_macros.svh"

module sens_frame_fsm import sens_pkg::*; (
   input  wire         MCLK,
   input  wire         c,
   input  wire         start,        // trigger strobe
   input  wire         hold,         // array reset level
   input  wire         video_mode,   // 1: free-running frames
   output logic        raw_bpf,
   output logic        raw_hact,
   output logic        raw_vact,
   output logic        frame_start,  // one clock at vact rise
   output logic [11:0] row,          // completed active lines
   output logic [11:0] col           // pixel index in hact
);

   // state durations in clocks
   localparam int T_PRE_VACT = `SENS_TRIGDLY * `SENS_LLINE;
   localparam int T_FIRST    = `SENS_NROWB * `SENS_LLINE;
   localparam int T_BPF      = `SENS_NBPF;
   localparam int T_PRE_HACT = `SENS_NGP1;
   localparam int T_HACT     = `SENS_NCOLS;
   localparam int T_AFTER    = `SENS_LLINE - `SENS_NBPF - `SENS_NGP1 - `SENS_NCOLS;
   localparam int T_LAST     = `SENS_NROWA * `SENS_LLINE - T_AFTER;  // after-hact already spent

   sens_state_t state;
   logic [15:0] cnt;   // clocks left in state, minus one

   // counter load for a state lasting n clocks
   function automatic logic [15:0] ld(input int n);
      return 16'(n - 1);
   endfunction

   always_ff @(posedge MCLK or posedge c) begin
      if (c) begin
         state       <= st_stop;
         cnt         <= '0;
         raw_bpf     <= 1'b0;
         raw_hact    <= 1'b0;
         raw_vact    <= 1'b0;
         frame_start <= 1'b0;
         row         <= '0;
         col         <= '0;
      end else if (hold) begin   // array reset, everything stops
         state       <= st_stop;
         cnt         <= '0;
         raw_bpf     <= 1'b0;
         raw_hact    <= 1'b0;
         raw_vact    <= 1'b0;
         frame_start <= 1'b0;
         row         <= '0;
         col         <= '0;
      end else begin
         frame_start <= 1'b0;
         if (state == st_hact) col <= col + 12'd1;   // next pixel
         if (cnt != 16'd0) begin
            cnt <= cnt - 16'd1;
         end else begin
            case (state)
               st_stop: begin
                  if (start) begin   // trigger only taken when idle
                     state <= st_pre_vact;
                     cnt   <= ld(T_PRE_VACT);
                  end
               end
               st_pre_vact, st_frame_gap: begin
                  raw_vact    <= 1'b1;
                  frame_start <= 1'b1;
                  row         <= '0;   // new frame
                  state       <= st_first_line;
                  cnt         <= ld(T_FIRST);
               end
               st_first_line: begin
                  raw_bpf <= 1'b1;
                  state   <= st_bpf;
                  cnt     <= ld(T_BPF);
               end
               st_bpf: begin
                  raw_bpf <= 1'b0;
                  state   <= st_pre_hact;
                  cnt     <= ld(T_PRE_HACT);
               end
               st_pre_hact: begin
                  raw_hact <= 1'b1;
                  col      <= '0;   // first pixel of line
                  state    <= st_hact;
                  cnt      <= ld(T_HACT);
               end
               st_hact: begin
                  raw_hact <= 1'b0;
                  row      <= row + 12'd1;   // line done
                  state    <= st_after_hact;
                  cnt      <= ld(T_AFTER);
               end
               st_after_hact: begin
                  if (row == 12'(`SENS_NROWS)) begin
                     state <= st_last_line;   // trailing blank lines
                     cnt   <= ld(T_LAST);
                  end else begin
                     raw_bpf <= 1'b1;   // next line
                     state   <= st_bpf;
                     cnt     <= ld(T_BPF);
                  end
               end
               st_last_line: begin
                  raw_vact <= 1'b0;
                  if (video_mode) begin
                     state <= st_frame_gap;
                     cnt   <= ld(`SENS_NVLO);
                  end else begin
                     state <= st_stop;   // still mode, wait for aro_n
                  end
               end
               default: state <= st_stop;
            endcase
         end
      end
   end

   // flags are mutually exclusive
   a_bpf_hact_excl : assert property (@(posedge MCLK) disable iff (c)
      !(raw_bpf && raw_hact))
      else $error("sens_frame_fsm: raw_bpf and raw_hact both high");

   // hact width is exactly one row of pixels
   a_hact_width : assert property (@(posedge MCLK) disable iff (c || hold)
      $rose(raw_hact) |-> raw_hact [*`SENS_NCOLS] ##1 !raw_hact)
      else $error("sens_frame_fsm: hact width differs from SENS_NCOLS");

endmodule

`default_nettype wire

//--- logic/sens_macros.svh
`ifndef SENS_MACROS_SVH
`define SENS_MACROS_SVH

// pixel bus
`define SENS_DW         12      // bits per pixel, lfsr taps assume 12

// line geometry in MCLK clocks
`define SENS_LLINE      48      // full line period
`define SENS_NCOLS      16      // hact width
`define SENS_NBPF       4       // black pixel flag width
`define SENS_NGP1       2       // bpf fall to hact rise

// frame geometry
`define SENS_NROWS      4       // active rows
`define SENS_NROWB      1       // blank lines after vact rise
`define SENS_NROWA      1       // blank lines before vact fall
`define SENS_NVLO       3       // vact low time between video frames, clocks

// readout trigger to vact, whole lines
`define SENS_TRIGDLY    2

// random pattern start value, reloaded every frame
`define SENS_LFSR_SEED  12'hACE

// after-hact gap is what is left of the line
// LLINE - NBPF - NGP1 - NCOLS must stay positive
// and NROWA*LLINE must exceed that gap

`endif

//--- logic/sens_pixel_gen.sv
`timescale 1ns/1ps
`default_nettype none
`include "sens_macros.svh"

module sens_pixel_gen import sens_pkg::*; (
   input  wire                    MCLK,
   input  wire                    c,
   input  wire sens_pattern_t     pattern,
   input  wire                    raw_bpf,
   input  wire                    raw_hact,
   input  wire                    raw_vact,
   input  wire                    frame_start,
   input  wire [11:0]             row,
   input  wire [11:0]             col,
   output logic [`SENS_DW-1:0]    d,
   output logic                   bpf,
   output logic                   hact,
   output logic                   vact,
   output logic                   vact_start
);

   logic [`SENS_DW-1:0] lfsr;       // random pattern state
   logic                lfsr_fb;
   logic [`SENS_DW-1:0] ramp_val;
   logic [`SENS_DW-1:0] pix;

   // x^12 + x^11 + x^10 + x^4 + 1
   assign lfsr_fb  = lfsr[11] ^ lfsr[10] ^ lfsr[9] ^ lfsr[3];
   assign ramp_val = {row[3:0], 8'h00} + col;   // row*256 + col, wraps at 4096
   assign pix      = (pattern == pat_ramp) ? ramp_val : lfsr;

   always_ff @(posedge MCLK or posedge c) begin
      if (c) begin
         lfsr <= `SENS_LFSR_SEED;
      end else if (frame_start) begin
         lfsr <= `SENS_LFSR_SEED;   // same sequence every frame
      end else if (raw_hact) begin
         lfsr <= {lfsr[10:0], lfsr_fb};   // one step per pixel
      end
   end

   // single output stage, 1 clock latency for data and flags
   always_ff @(posedge MCLK or posedge c) begin
      if (c) begin
         d          <= '0;
         bpf        <= 1'b0;
         hact       <= 1'b0;
         vact       <= 1'b0;
         vact_start <= 1'b0;
      end else begin
         d          <= raw_hact ? pix : '0;   // black pixels and blanking read 0
         bpf        <= raw_bpf;
         hact       <= raw_hact;
         vact       <= raw_vact;
         vact_start <= frame_start;
      end
   end

   // bus is quiet outside active pixels
   a_d_quiet : assert property (@(posedge MCLK) disable iff (c)
      !hact |-> (d == '0))
      else $error("sens_pixel_gen: d nonzero with hact low, d=%h", d);

endmodule

`default_nettype wire

//--- logic/sens_pkg.sv
`default_nettype none

package sens_pkg;

   // line/frame timing states
   typedef enum logic [3:0] {
      st_stop,         // idle, waiting for trigger
      st_pre_vact,     // trigger delay
      st_first_line,   // blank lines before first row
      st_bpf,          // black pixels
      st_pre_hact,     // gap bpf -> hact
      st_hact,         // active pixels
      st_after_hact,   // rest of line
      st_last_line,    // blank lines after last row
      st_frame_gap     // vact low, video mode only
   } sens_state_t;

   // pixel data source
   typedef enum logic {
      pat_ramp,        // row*256 + col
      pat_random       // 12-bit lfsr
   } sens_pattern_t;

endpackage

`default_nettype wire

//--- logic/sens_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "sens_macros.svh"

module sens_top import sens_pkg::*; (
   input  wire                  MCLK,
   input  wire                  c,            // async reset, active high
   input  wire                  aro_n,        // readout trigger
   input  wire                  arst_n,       // array reset
   input  wire                  video_mode,   // 0 still, 1 video
   input  wire sens_pattern_t   pattern,
   output wire [`SENS_DW-1:0]   d,
   output wire                  bpf,
   output wire                  hact,
   output wire                  vact,
   output wire                  vact_start
);

   wire        start;         // trigger strobe
   wire        hold;          // array reset, synced
   wire        raw_bpf;
   wire        raw_hact;
   wire        raw_vact;
   wire        frame_start;
   wire [11:0] row;
   wire [11:0] col;

   // pin synchronizers
   sens_trigger u_trigger (
      .MCLK   (MCLK),
      .c      (c),
      .aro_n  (aro_n),
      .arst_n (arst_n),
      .start  (start),
      .hold   (hold)
   );

   // line and frame timing
   sens_frame_fsm u_frame_fsm (
      .MCLK        (MCLK),
      .c           (c),
      .start       (start),
      .hold        (hold),
      .video_mode  (video_mode),
      .raw_bpf     (raw_bpf),
      .raw_hact    (raw_hact),
      .raw_vact    (raw_vact),
      .frame_start (frame_start),
      .row         (row),
      .col         (col)
   );

   // pattern and output registers
   sens_pixel_gen u_pixel_gen (
      .MCLK        (MCLK),
      .c           (c),
      .pattern     (pattern),
      .raw_bpf     (raw_bpf),
      .raw_hact    (raw_hact),
      .raw_vact    (raw_vact),
      .frame_start (frame_start),
      .row         (row),
      .col         (col),
      .d           (d),
      .bpf         (bpf),
      .hact        (hact),
      .vact        (vact),
      .vact_start  (vact_start)
   );

endmodule

`default_nettype wire

//--- logic/sens_trigger.sv
`timescale 1ns/1ps
`default_nettype none

module sens_trigger (
   input  wire  MCLK,
   input  wire  c,
   input  wire  aro_n,    // readout trigger pin, async, active low
   input  wire  arst_n,   // array reset pin, async, active low
   output logic start,    // one clock per aro_n fall
   output logic hold      // sensor held stopped
);

   logic aro_s1, aro_s2;   // two-flop sync
   logic aro_s3;           // previous synced level, for edge detect
   logic arst_s1, arst_s2;

   always_ff @(posedge MCLK or posedge c) begin
      if (c) begin
         aro_s1  <= 1'b1;   // pin idles high
         aro_s2  <= 1'b1;
         aro_s3  <= 1'b1;
         arst_s1 <= 1'b0;   // come out of reset still held
         arst_s2 <= 1'b0;
         start   <= 1'b0;
      end else begin
         aro_s1  <= aro_n;
         aro_s2  <= aro_s1;
         aro_s3  <= aro_s2;
         arst_s1 <= arst_n;
         arst_s2 <= arst_s1;
         start   <= aro_s3 & ~aro_s2;   // registered falling edge
      end
   end

   assign hold = ~arst_s2;

   // a held-low pin must not retrigger
   a_start_single : assert property (@(posedge MCLK) disable iff (c)
      start |=> !start)
      else $error("sens_trigger: start high on two consecutive clocks");

endmodule

`default_nettype wire

//--- sim/tb_sens_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "sens_macros.svh"

module tb_sens_top import sens_pkg::*; ();

   // aro_n fall seen at edge k, start set at k+2, fsm acts at k+3,
   // raw_vact after the trigger delay, output reg +1, monitor sees it +1
   localparam int VACT_LAT  = `SENS_TRIGDLY * `SENS_LLINE + 5;
   localparam int FRAME_CYC = (`SENS_TRIGDLY + `SENS_NROWB + `SENS_NROWS + `SENS_NROWA)
                              * `SENS_LLINE + `SENS_NVLO;
   localparam int WATCHDOG_CYC = 5 * (3 * FRAME_CYC + 19);   // 5 phases with idle gaps up to 19

   logic MCLK, c, aro_n, arst_n, video_mode;
   sens_pattern_t pattern;
   wire [`SENS_DW-1:0] d;
   wire bpf, hact, vact, vact_start;

   // monitor state updated on the clock
   int cyc, aro_fall_cyc, bpf_rise_cyc, hact_fall_cyc, vact_rise_cyc, vact_fall_cyc;
   int vact_cnt, tb_row, tb_col;
   logic prev_bpf, prev_hact, prev_vact, prev_aro, line_seen;
   logic [11:0] tb_lfsr;
   int unsigned rnd_state = 88;
   int exp_cnt;

   sens_top u_sens_top (
      .MCLK       (MCLK),
      .c          (c),
      .aro_n      (aro_n),
      .arst_n     (arst_n),
      .video_mode (video_mode),
      .pattern    (pattern),
      .d          (d),
      .bpf        (bpf),
      .hact       (hact),
      .vact       (vact),
      .vact_start (vact_start)
   );

   initial begin
      MCLK = 1'b0;
      forever #50 MCLK = ~MCLK;   // 100 ns period
   end

   function automatic int unsigned lcg_next(input int unsigned s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // x^12+x^11+x^10+x^4+1 shifting left with feedback into bit 0
   function automatic logic [11:0] lfsr_step(input logic [11:0] s);
      return {s[10:0], s[11] ^ s[10] ^ s[9] ^ s[3]};
   endfunction

   function automatic logic [11:0] ramp_pixel(input int r, input int col_i);
      return 12'((r * 256 + col_i) % 4096);
   endfunction

   task automatic stop_fail();
      $display("TEST RESULT: FAIL");
      $fatal(1);
   endtask

   task automatic report_err(input string name, input logic [31:0] got, input logic [31:0] want);
      $display("ERR %s got=0x%0h exp=0x%0h", name, got, want);
      stop_fail();
   endtask

   task automatic report_fail(input string msg);
      $display("%s", msg);
      stop_fail();
   endtask

   task automatic next_cycle();
      @(posedge MCLK);
      #5;   // drive point
   endtask

   task automatic idle_random();
      rnd_state = lcg_next(rnd_state);
      repeat (4 + int'(rnd_state[19:16])) next_cycle();
   endtask

   task automatic pulse_trigger();
      aro_n = 1'b0;
      repeat (3) next_cycle();
      aro_n = 1'b1;
   endtask

   task automatic wait_vact(input logic level, input int max_cyc);
      int n;
      n = 0;
      while (vact !== level) begin
         next_cycle();
         n++;
         assert (n <= max_cyc) else report_fail("vact did not change level in time");
      end
   endtask

   task automatic expect_idle(input string when);
      assert (d == '0 && !bpf && !hact && !vact && !vact_start)
         else report_fail({"outputs not idle ", when});
   endtask

   // trigger from idle and check the vact rise latency
   task automatic triggered_frame();
      idle_random();
      pulse_trigger();
      wait_vact(1'b1, VACT_LAT + 8);
      next_cycle();   // let the monitor see the rise
      assert (vact_rise_cyc - aro_fall_cyc == VACT_LAT)
         else report_err("vact latency", vact_rise_cyc - aro_fall_cyc, VACT_LAT);
   endtask

   task automatic expect_no_new_frame();
      exp_cnt = vact_cnt;
      repeat (FRAME_CYC) next_cycle();
      assert (vact_cnt == exp_cnt) else report_fail("vact started without a trigger");
   endtask

   always @(posedge MCLK) begin
      if (c) begin
         cyc       <= 0;
         vact_cnt  <= 0;
         tb_row    <= 0;
         tb_col    <= 0;
         prev_bpf  <= 1'b0;
         prev_hact <= 1'b0;
         prev_vact <= 1'b0;
         prev_aro  <= 1'b1;
         line_seen <= 1'b0;
         tb_lfsr   <= `SENS_LFSR_SEED;
      end else begin
         cyc       <= cyc + 1;
         prev_bpf  <= bpf;
         prev_hact <= hact;
         prev_vact <= vact;
         prev_aro  <= aro_n;
         if (prev_aro && !aro_n) aro_fall_cyc <= cyc;
         if (vact_start) begin   // reseed models on a new frame
            tb_row    <= 0;
            tb_lfsr   <= `SENS_LFSR_SEED;
            line_seen <= 1'b0;
         end
         if (vact && !prev_vact) begin
            vact_rise_cyc <= cyc;
            vact_cnt      <= vact_cnt + 1;
         end
         if (!vact && prev_vact) begin
            vact_fall_cyc <= cyc;
            assert (tb_row == `SENS_NROWS) else report_err("hact per vact", tb_row, `SENS_NROWS);
            assert (cyc - hact_fall_cyc == `SENS_NROWA * `SENS_LLINE)
               else report_err("vact fall delay", cyc - hact_fall_cyc, `SENS_NROWA * `SENS_LLINE);
         end
         if (bpf && !prev_bpf) begin
            bpf_rise_cyc <= cyc;
            line_seen    <= 1'b1;
            if (line_seen) begin   // line period
               assert (cyc - bpf_rise_cyc == `SENS_LLINE)
                  else report_err("bpf period", cyc - bpf_rise_cyc, `SENS_LLINE);
            end else begin   // blank lines after vact rise
               assert (cyc - vact_rise_cyc == `SENS_NROWB * `SENS_LLINE)
                  else report_err("first bpf", cyc - vact_rise_cyc, `SENS_NROWB * `SENS_LLINE);
            end
         end
         if (!bpf && prev_bpf)
            assert (cyc - bpf_rise_cyc == `SENS_NBPF)
               else report_err("bpf width", cyc - bpf_rise_cyc, `SENS_NBPF);
         if (hact && !prev_hact)
            assert (cyc - bpf_rise_cyc == `SENS_NBPF + `SENS_NGP1)
               else report_err("hact rise", cyc - bpf_rise_cyc, `SENS_NBPF + `SENS_NGP1);
         if (!hact && prev_hact) begin
            hact_fall_cyc <= cyc;
            tb_row        <= tb_row + 1;
            assert (tb_col == `SENS_NCOLS) else report_err("hact width", tb_col, `SENS_NCOLS);
         end
         if (hact) begin   // pixel check
            if (pattern == pat_ramp) begin
               assert (d == ramp_pixel(tb_row, tb_col))
                  else report_err("d", 32'(d), 32'(ramp_pixel(tb_row, tb_col)));
            end else begin
               assert (d == tb_lfsr) else report_err("d", 32'(d), 32'(tb_lfsr));
            end
            tb_col  <= tb_col + 1;
            tb_lfsr <= lfsr_step(tb_lfsr);
         end else begin
            tb_col <= 0;
         end
      end
   end

   a_vs_rise : assert property (@(posedge MCLK) disable iff (c) vact_start |-> $rose(vact))
      else report_fail("vact_start high without a vact rise");
   a_rise_vs : assert property (@(posedge MCLK) disable iff (c) $rose(vact) |-> vact_start)
      else report_fail("vact rose without vact_start");
   a_d_zero : assert property (@(posedge MCLK) disable iff (c) !hact |-> d == '0)
      else report_err("d", 32'(d), 32'h0);
   a_excl : assert property (@(posedge MCLK) disable iff (c) !(bpf && hact))
      else report_fail("bpf and hact high together");

   initial begin
      #(WATCHDOG_CYC * 100);
      report_fail("watchdog expired, run took too long");
   end

   initial begin
      c          = 1'b1;
      aro_n      = 1'b1;
      arst_n     = 1'b1;
      video_mode = 1'b0;
      pattern    = pat_ramp;
      repeat (2) next_cycle();
      expect_idle("in reset");
      c = 1'b0;
      repeat (3) next_cycle();
      expect_idle("after reset");
      // array reset blocks the trigger
      arst_n = 1'b0;
      repeat (3) next_cycle();
      pulse_trigger();
      repeat (VACT_LAT + 8) next_cycle();
      assert (vact_cnt == 0 && !vact) else report_fail("vact appeared while arst_n was low");
      arst_n = 1'b1;
      // still mode ramp with an extra trigger inside the frame
      triggered_frame();
      pulse_trigger();
      wait_vact(1'b0, FRAME_CYC);
      expect_no_new_frame();
      // still mode random
      pattern = pat_random;
      triggered_frame();
      wait_vact(1'b0, FRAME_CYC);
      // video mode makes a second frame on its own
      pattern = pat_ramp;
      video_mode = 1'b1;
      triggered_frame();
      wait_vact(1'b0, FRAME_CYC);
      wait_vact(1'b1, `SENS_NVLO + 4);
      next_cycle();
      assert (vact_rise_cyc - vact_fall_cyc == `SENS_NVLO)
         else report_err("vact low time", vact_rise_cyc - vact_fall_cyc, `SENS_NVLO);
      video_mode = 1'b0;   // stop after this frame
      wait_vact(1'b0, FRAME_CYC);
      expect_no_new_frame();
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire
